//--- vlog.f
+incdir+tests
hw/aes_cfg_pkg.sv
hw/aes_tables_pkg.sv
hw/aes_block_capture.sv
hw/aes_round_sequencer.sv
hw/aes_cipher_round.sv
hw/aes_result_hold.sv
hw/aes_encrypt_core.sv
tests/aes_encrypt_tb.sv

//--- Bender.yml
package:
  name: aes_encrypt_core

sources:
  - files:
      - hw/aes_cfg_pkg.sv
      - hw/aes_tables_pkg.sv
      - hw/aes_block_capture.sv
      - hw/aes_round_sequencer.sv
      - hw/aes_cipher_round.sv
      - hw/aes_result_hold.sv
      - hw/aes_encrypt_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/aes_encrypt_tb.sv

//--- tests/aes_ref_model.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// Substitution table of the model.
// It is rebuilt from the field inverse and the affine map at time zero.
logic [7:0] sbox_ref [256];

// Multiply two bytes in GF(2^8) by shift and add.
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  logic [7:0] y;
  p = 8'h00;
  x = a;
  y = b;
  for (int i = 0; i < 8; i++) begin
    if (y[0]) begin
      p = p ^ x;
    end
    // Reduce by x^8 + x^4 + x^3 + x + 1 whenever bit 7 falls out.
    x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
    y = y >> 1;
  end
  return p;
endfunction

// Rotate a byte left by n bits.
function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
  return (b << n) | (b >> (8 - n));
endfunction

// The S-box is the multiplicative inverse followed by the affine map.
// The inverse is v^254, which also sends zero to zero.
task automatic build_sbox();
  logic [7:0] inv;
  for (int v = 0; v < 256; v++) begin
    inv = 8'h01;
    for (int k = 0; k < 254; k++) begin
      inv = gf_mul(inv, v[7:0]);
    end
    sbox_ref[v] = inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3)
                ^ rotl8(inv, 4) ^ 8'h63;
  end
endtask

// One AES round on a block.
// Byte k of the block is input byte k of FIPS-197, so row r of column c is byte r + 4c.
function automatic block_t apply_round(input block_t blk, input block_t key, input bit is_last);
  logic [7:0] s [16];
  logic [7:0] t [16];
  logic [7:0] a0;
  logic [7:0] a1;
  logic [7:0] a2;
  logic [7:0] a3;
  block_t     res;
  for (int k = 0; k < 16; k++) begin
    s[k] = sbox_ref[blk[127 - 8*k -: 8]];
  end
  // Row r moves left by r columns.
  for (int c = 0; c < 4; c++) begin
    for (int r = 0; r < 4; r++) begin
      t[r + 4*c] = s[r + 4*((c + r) % 4)];
    end
  end
  for (int c = 0; c < 4; c++) begin
    a0 = t[4*c];
    a1 = t[4*c + 1];
    a2 = t[4*c + 2];
    a3 = t[4*c + 3];
    if (is_last) begin
      s[4*c]     = a0;
      s[4*c + 1] = a1;
      s[4*c + 2] = a2;
      s[4*c + 3] = a3;
    end else begin
      s[4*c]     = gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3;
      s[4*c + 1] = a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3;
      s[4*c + 2] = a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03);
      s[4*c + 3] = gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02);
    end
  end
  for (int k = 0; k < 16; k++) begin
    res[127 - 8*k -: 8] = s[k];
  end
  return res ^ key;
endfunction

// Whitening with slot 15, then round i uses slot 15 - i.
function automatic block_t encrypt_ref(input block_t plain, input round_keys_t keys,
                                       input int nr);
  block_t st;
  st = plain ^ keys[15];
  for (int i = 1; i <= nr; i++) begin
    st = apply_round(st, keys[15 - i], i == nr);
  end
  return st;
endfunction

// AES-128 key schedule.
// Round key r lands in slot 15 - r; the unused slots stay zero.
function automatic round_keys_t expand_key_128(input block_t key);
  logic [31:0] w [44];
  logic [31:0] tmp;
  logic [7:0]  rcon;
  round_keys_t rk;
  rk   = '0;
  rcon = 8'h01;
  for (int i = 0; i < 4; i++) begin
    w[i] = key[127 - 32*i -: 32];
  end
  for (int i = 4; i < 44; i++) begin
    tmp = w[i - 1];
    if (i % 4 == 0) begin
      tmp = {tmp[23:0], tmp[31:24]};
      tmp = {sbox_ref[tmp[31:24]], sbox_ref[tmp[23:16]],
             sbox_ref[tmp[15:8]], sbox_ref[tmp[7:0]]};
      tmp[31:24] = tmp[31:24] ^ rcon;
      rcon = gf_mul(rcon, 8'h02);
    end
    w[i] = w[i - 4] ^ tmp;
  end
  for (int r = 0; r <= 10; r++) begin
    rk[15 - r] = {w[4*r], w[4*r + 1], w[4*r + 2], w[4*r + 3]};
  end
  return rk;
endfunction

`endif

//--- tests/aes_encrypt_tb.sv
`timescale 1ns/10ps

module aes_encrypt_tb
  import aes_cfg_pkg::*;
();

  // Block budget for the run and the cycle limit taken from it.
  localparam int unsigned MAX_BLOCKS       = 40;
  localparam int unsigned CYCLES_PER_BLOCK = 20;
  localparam int unsigned MAX_CYCLES       = MAX_BLOCKS * CYCLES_PER_BLOCK + 100;
  localparam int unsigned N_RANDOM         = 36;
  localparam int unsigned HOLD_CYCLES      = 2;

  // FIPS-197 appendix B vector.
  localparam block_t KAT_KEY    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam block_t KAT_PLAIN  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam block_t KAT_CIPHER = 128'h3925841d02dc09fbdc118597196a0b32;

  logic        eph1;
  logic        rst_n;
  logic        ready;
  block_t      plain_text;
  key_size_t   key_size;
  round_keys_t key_words;
  block_t      cipher;
  logic        done;

  integer      seed;
  int unsigned cycles = 0;

  `include "aes_ref_model.svh"

  aes_encrypt_core aes_encrypt_core_i (
    .eph1       (eph1),
    .rst_n      (rst_n),
    .ready      (ready),
    .plain_text (plain_text),
    .key_size   (key_size),
    .key_words  (key_words),
    .cipher     (cipher),
    .done       (done)
  );

  initial begin
    eph1 = 1'b0;
    forever #10 eph1 = ~eph1;
  end

  // Prints the fail message and ends the run.
  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic compare_value(input string name, input block_t exp, input block_t got);
    assert (got === exp) else begin
      $display("FAIL %s: expected %0h, actual %0h", name, exp, got);
      stop_with_failure();
    end
  endtask

  // Cycle limit for the whole run.
  always @(posedge eph1) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      stop_with_failure();
    end
  end

  // Selector 00 runs 10 rounds, 01 runs 12, and 10 or 11 run 14.
  function automatic int rounds_for(input key_size_t ks);
    if (ks == 2'b00) begin
      return 10;
    end else if (ks == 2'b01) begin
      return 12;
    end
    return 14;
  endfunction

  function automatic block_t random_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // One block from a low cycle of ready to the held result.
  // It is entered and left just after a falling edge.
  task automatic run_block(input string name, input block_t pt, input key_size_t ks,
                           input round_keys_t keys, input block_t exp);
    block_t prev;
    int     lat;
    prev = cipher;
    @(posedge eph1);
    ready <= 1'b0;
    @(posedge eph1);
    ready      <= 1'b1;
    plain_text <= pt;
    key_size   <= ks;
    key_words  <= keys;
    // Ready was seen low on this edge, so done is gone and the old result stays.
    @(negedge eph1);
    compare_value({name, " done_cleared"}, 1'b0, done);
    compare_value({name, " cipher_kept"}, prev, cipher);
    // First edge with ready high.
    @(posedge eph1);
    lat = 0;
    do begin
      @(posedge eph1);
      lat++;
      @(negedge eph1);
    end while (!done);
    compare_value({name, " latency"}, rounds_for(ks), lat);
    compare_value({name, " cipher"}, exp, cipher);
    // Done and the result stay while ready stays high.
    repeat (HOLD_CYCLES) begin
      @(negedge eph1);
      compare_value({name, " done_held"}, 1'b1, done);
      compare_value({name, " cipher_held"}, exp, cipher);
    end
  endtask

  initial begin
    block_t      pt;
    block_t      exp;
    round_keys_t keys;
    key_size_t   ks;
    seed       = 32'h4d47_a7cb;
    rst_n      = 1'b0;
    ready      = 1'b0;
    plain_text = '0;
    key_size   = '0;
    key_words  = '0;
    build_sbox();
    repeat (3) @(posedge eph1);
    rst_n <= 1'b1;
    @(negedge eph1);
    compare_value("reset done", 1'b0, done);
    compare_value("reset cipher", '0, cipher);

    // The model is checked against the published vector before the DUT.
    keys = expand_key_128(KAT_KEY);
    exp  = encrypt_ref(KAT_PLAIN, keys, 10);
    compare_value("kat model", KAT_CIPHER, exp);
    run_block("kat", KAT_PLAIN, 2'b00, keys, KAT_CIPHER);

    // Every selector value comes round in turn, 11 included.
    for (int i = 0; i < N_RANDOM; i++) begin
      pt = random_block();
      for (int s = 1; s <= KEY_SLOTS; s++) begin
        keys[s] = random_block();
      end
      ks  = key_size_t'(i % 4);
      exp = encrypt_ref(pt, keys, rounds_for(ks));
      run_block($sformatf("random_%0d ks=%b", i, ks), pt, ks, keys, exp);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- hw/aes_encrypt_core.sv
`timescale 1ns/10ps

module aes_encrypt_core
  import aes_cfg_pkg::*;
(
  input  logic        eph1,
  input  logic        rst_n,
  input  logic        ready,
  input  block_t      plain_text,
  input  key_size_t   key_size,
  input  round_keys_t key_words,
  output block_t      cipher,
  output logic        done
);

  // Captured plaintext and the one-cycle start.
  aes_req_t   req;
  // Round key and first/last flags for the current cycle.
  round_ctl_t ctl;
  // Combinational output of the current round.
  block_t     round_out;

  // Input side.
  aes_block_capture u_capture (
    .eph1       (eph1),
    .rst_n      (rst_n),
    .ready      (ready),
    .plain_text (plain_text),
    .req        (req)
  );

  // Round counter and key selection.
  aes_round_sequencer u_sequencer (
    .eph1      (eph1),
    .rst_n     (rst_n),
    .start     (req.start),
    .key_size  (key_size),
    .key_words (key_words),
    .ctl       (ctl)
  );

  // One full round per cycle; the whitening key is always slot 15.
  aes_cipher_round u_round (
    .eph1       (eph1),
    .rst_n      (rst_n),
    .req        (req),
    .ctl        (ctl),
    .whiten_key (key_words[FIRST_SLOT]),
    .round_out  (round_out)
  );

  // Output side.
  aes_result_hold u_result (
    .eph1      (eph1),
    .rst_n     (rst_n),
    .last      (ctl.last),
    .ready     (ready),
    .round_out (round_out),
    .cipher    (cipher),
    .done      (done)
  );

endmodule

//--- hw/aes_result_hold.sv
`timescale 1ns/10ps

module aes_result_hold
  import aes_cfg_pkg::*;
(
  input  logic   eph1,
  input  logic   rst_n,
  input  logic   last,
  input  logic   ready,
  input  block_t round_out,
  output block_t cipher,
  output logic   done
);

  // The final round result only exists for one cycle.
  // It is caught here and held until the next block ends.
  always_ff @(posedge eph1 or negedge rst_n) begin
    if (!rst_n) begin
      cipher <= '0;
    end else if (last) begin
      cipher <= round_out;
    end
  end

  // Done rises with the captured result.
  // Dropping ready clears it. The result itself stays.
  always_ff @(posedge eph1 or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (!ready) begin
      done <= 1'b0;
    end else if (last) begin
      done <= 1'b1;
    end
  end

  // Each block has exactly one final round, so last is a single cycle.
  a_last_pulse : assert property (
    @(posedge eph1) disable iff (!rst_n)
    last |=> !last
  ) else $error("last round flag held for two cycles");

endmodule

//--- hw/aes_cipher_round.sv
`timescale 1ns/10ps

module aes_cipher_round
  import aes_cfg_pkg::*;
  import aes_tables_pkg::*;
(
  input  logic       eph1,
  input  logic       rst_n,
  input  aes_req_t   req,
  input  round_ctl_t ctl,
  input  block_t     whiten_key,
  output block_t     round_out
);

  // Round state carried from one cycle to the next.
  block_t state_q;

  state_t round_in;
  state_t sub_bytes;
  state_t shifted;
  state_t mixed;

  // The first cycle of a block starts from the whitened plaintext.
  // Every later cycle starts from the previous round result.
  assign round_in = ctl.first ? (req.block ^ whiten_key) : state_q;

  // SubBytes works on each byte on its own.
  always_comb begin
    for (int i = 0; i < N_BYTES; i++) begin
      sub_bytes[i] = SBOX[round_in[i]];
    end
  end

  // ShiftRows rotates row r left by r columns.
  // Row r of column c sits at byte 15 - 4c - r.
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[15 - 4*c - r] = sub_bytes[15 - 4*((c + r) % 4) - r];
      end
    end
  end

  // MixColumns multiplies each column by the circulant 2 3 1 1.
  // Byte base is row 0 of the column and base-3 is row 3.
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mixed[15 - 4*c] = gf_x2(shifted[15 - 4*c]) ^ gf_x3(shifted[14 - 4*c])
                      ^ shifted[13 - 4*c] ^ shifted[12 - 4*c];
      mixed[14 - 4*c] = shifted[15 - 4*c] ^ gf_x2(shifted[14 - 4*c])
                      ^ gf_x3(shifted[13 - 4*c]) ^ shifted[12 - 4*c];
      mixed[13 - 4*c] = shifted[15 - 4*c] ^ shifted[14 - 4*c]
                      ^ gf_x2(shifted[13 - 4*c]) ^ gf_x3(shifted[12 - 4*c]);
      mixed[12 - 4*c] = gf_x3(shifted[15 - 4*c]) ^ shifted[14 - 4*c]
                      ^ shifted[13 - 4*c] ^ gf_x2(shifted[12 - 4*c]);
    end
  end

  // The final round has no MixColumns.
  // The key and the state share the same byte layout, so AddRoundKey is one XOR.
  assign round_out = block_t'(ctl.last ? shifted : mixed) ^ ctl.round_key;

  // The state register takes a new round every cycle, busy or not.
  // Only the result side decides which value is kept.
  always_ff @(posedge eph1 or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '0;
    end else begin
      state_q <= round_out;
    end
  end

  // A block that starts must bring a defined plaintext into the state.
  a_block_known : assert property (
    @(posedge eph1) disable iff (!rst_n)
    req.start |-> !$isunknown(req.block)
  ) else $error("start cycle carries an undefined block");

endmodule

//--- hw/aes_round_sequencer.sv
`timescale 1ns/10ps

module aes_round_sequencer
  import aes_cfg_pkg::*;
(
  input  logic        eph1,
  input  logic        rst_n,
  input  logic        start,
  input  key_size_t   key_size,
  input  round_keys_t key_words,
  output round_ctl_t  ctl
);

  key_len_e key_len;
  slot_t    last_slot;
  slot_t    slot;
  slot_t    slot_q;
  logic     busy_q;
  logic     active;

  // Selector 00 is 128 bits, 01 is 192 bits and 1x is 256 bits.
  always_comb begin
    if (key_size[1]) begin
      key_len = KEY_256;
    end else if (key_size[0]) begin
      key_len = KEY_192;
    end else begin
      key_len = KEY_128;
    end
  end

  // Longer keys run more rounds, so they stop at a lower slot.
  always_comb begin
    case (key_len)
      KEY_192: last_slot = LAST_SLOT_192;
      KEY_256: last_slot = LAST_SLOT_256;
      default: last_slot = LAST_SLOT_128;
    endcase
  end

  // Slot 15 whitens the plaintext in the start cycle.
  // Round 1 runs in that same cycle, so its key comes from the slot below.
  // A start also overrides a block that is still in progress.
  assign slot   = start ? slot_t'(FIRST_SLOT - 1'b1) : slot_q;
  assign active = start | busy_q;

  assign ctl.first     = start;
  assign ctl.last      = active && (slot == last_slot);
  assign ctl.round_key = key_words[slot];

  // The counter steps down once per round and freezes after the last one.
  // Holding the slot keeps the key index in range while idle.
  always_ff @(posedge eph1 or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      slot_q <= FIRST_SLOT;
    end else if (active) begin
      busy_q <= !ctl.last;
      if (!ctl.last) begin
        slot_q <= slot - 1'b1;
      end
    end
  end

  // The key size is held stable per block, so the count never overshoots.
  a_slot_floor : assert property (
    @(posedge eph1) disable iff (!rst_n)
    busy_q |-> (slot_q >= last_slot)
  ) else $error("round slot fell below the final slot");

endmodule

//--- hw/aes_block_capture.sv
`timescale 1ns/10ps

module aes_block_capture
  import aes_cfg_pkg::*;
(
  input  logic     eph1,
  input  logic     rst_n,
  input  logic     ready,
  input  block_t   plain_text,
  output aes_req_t req
);

  // Two samples of the ready level.
  // The pair shows a low to high step one cycle after it happens.
  logic   ready_q1;
  logic   ready_q2;
  block_t plain_q;

  always_ff @(posedge eph1 or negedge rst_n) begin
    if (!rst_n) begin
      ready_q1 <= 1'b0;
      ready_q2 <= 1'b0;
    end else begin
      ready_q1 <= ready;
      ready_q2 <= ready_q1;
    end
  end

  // The plaintext is taken on the same edge that first sees ready high.
  // It then stays put for the whole block even if the pins change.
  always_ff @(posedge eph1) begin
    if (ready && !ready_q1) begin
      plain_q <= plain_text;
    end
  end

  // Start is the cycle right after the rising step of ready.
  assign req.start = ready_q1 & ~ready_q2;
  assign req.block = plain_q;

  // The start cycle must carry the plaintext from the edge that saw ready rise.
  a_block_captured : assert property (
    @(posedge eph1) disable iff (!rst_n)
    req.start |-> (req.block == $past(plain_text))
  ) else $error("start cycle does not carry the captured plaintext");

endmodule

//--- hw/aes_tables_pkg.sv
package aes_tables_pkg;

  import aes_cfg_pkg::*;

  // Reduction constant of the field polynomial x^8 + x^4 + x^3 + x + 1.
  localparam logic [BYTE_W-1:0] RED_POLY = 8'h1b;

  // Forward Rijndael S-box.
  // Entry n holds the substitute of byte value n, in the usual row order.
  localparam logic [BYTE_W-1:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Multiply by x in GF(2^8).
  // A carry out of bit 7 is folded back with the reduction constant.
  function automatic logic [BYTE_W-1:0] gf_x2(input logic [BYTE_W-1:0] b);
    logic [BYTE_W-1:0] shifted;
    shifted = {b[BYTE_W-2:0], 1'b0};
    return b[BYTE_W-1] ? (shifted ^ RED_POLY) : shifted;
  endfunction

  // Multiply by x+1, which is the doubled byte plus the byte itself.
  function automatic logic [BYTE_W-1:0] gf_x3(input logic [BYTE_W-1:0] b);
    return gf_x2(b) ^ b;
  endfunction

endpackage

//--- hw/aes_cfg_pkg.sv
package aes_cfg_pkg;

  // Block geometry.
  // AES fixes all of these sizes.
  localparam int unsigned BLOCK_W   = 128;
  localparam int unsigned BYTE_W    = 8;
  localparam int unsigned N_BYTES   = 16;
  localparam int unsigned KEY_SLOTS = 15;

  // One block or one round key.
  typedef logic [BLOCK_W-1:0] block_t;

  // The same block seen as the AES state.
  // Byte 15 is the most significant byte and bytes run column-major,
  // so bytes 15..12 form the first column with byte 15 in row 0.
  typedef logic [N_BYTES-1:0][BYTE_W-1:0] state_t;

  // Raw key size selector as it arrives on the pins.
  typedef logic [1:0] key_size_t;

  // Index into the round key array.
  typedef logic [3:0] slot_t;

  // Pre-expanded round keys.
  // Slot 15 is used first.
  typedef block_t [KEY_SLOTS:1] round_keys_t;

  // Slot of the initial AddRoundKey key.
  localparam slot_t FIRST_SLOT = 4'd15;

  // Slot of the final round for each key length.
  // The counter starts at 14 for round 1, so 10, 12 or 14 rounds end here.
  localparam slot_t LAST_SLOT_128 = 4'd5;
  localparam slot_t LAST_SLOT_192 = 4'd3;
  localparam slot_t LAST_SLOT_256 = 4'd1;

  // Decoded key length; selector 1x maps to 256 bits.
  typedef enum logic [1:0] {
    KEY_128 = 2'b00,
    KEY_192 = 2'b01,
    KEY_256 = 2'b10
  } key_len_e;

  // Request from the input side to the round datapath.
  typedef struct packed {
    block_t block;
    logic   start;
  } aes_req_t;

  // Per-cycle round control from the sequencer.
  typedef struct packed {
    logic   first;
    logic   last;
    block_t round_key;
  } round_ctl_t;

endpackage
